// File: flist.f
+incdir+verilog
verilog/mem_pkg.sv
verilog/bank_sel.sv
verilog/spram.sv
verilog/load_align.sv
verilog/banked_mem.sv
test/tb_banked_mem.sv

// File: test/mem_cases.txt
# op addr size(0 byte,1 half,2 word) unsigned wdata expected(hex data, E error, - none)
# op with + is issued right after the previous request, with no idle cycle
# Word stores across all banks, then word loads
W 0000 2 0 11223344 -
W 0004 2 0 55667788 -
W 0008 2 0 99aabbcc -
W 000c 2 0 ddeeff00 -
W 0010 2 0 a5a5a5a5 -
W 3ffc 2 0 cafef00d -
W 2008 2 0 0badbeef -
R 0000 2 0 0 11223344
R 0004 2 0 0 55667788
R 0008 2 0 0 99aabbcc
R 000c 2 0 0 ddeeff00
R 0010 2 0 0 a5a5a5a5
R 3ffc 2 0 0 cafef00d
R 2008 2 0 0 0badbeef
# Byte stores into each lane of one word
W 0100 2 0 00000000 -
W 0100 0 0 000000a1 -
R 0100 2 0 0 000000a1
W 0101 0 0 000000b2 -
R 0100 2 0 0 0000b2a1
W 0102 0 0 ffffffc3 -
R 0100 2 0 0 00c3b2a1
W 0103 0 0 000000d4 -
R 0100 2 0 0 d4c3b2a1
W 0114 2 0 12345678 -
W 0116 0 0 000000ff -
R 0114 2 0 0 12ff5678
W 0114 1 0 0000abcd -
R 0114 2 0 0 12ffabcd
W 0116 1 0 00001111 -
R 0114 2 0 0 1111abcd
# Sign and zero extension
R 0100 0 0 0 ffffffa1
R 0100 0 1 0 000000a1
R 0101 0 0 0 ffffffb2
R 0101 0 1 0 000000b2
R 0102 0 0 0 ffffffc3
R 0103 0 1 0 000000d4
R 0100 1 0 0 ffffb2a1
R 0100 1 1 0 0000b2a1
R 0102 1 0 0 ffffd4c3
R 0102 1 1 0 0000d4c3
R 0000 0 0 0 00000044
R 0003 0 0 0 00000011
R 0002 1 0 0 00001122
R 0000 1 0 0 00003344
R 3fff 0 0 0 ffffffca
R 3ffe 1 1 0 0000cafe
R 3ffc 1 0 0 fffff00d
# Misaligned accesses leave memory alone
W 0200 2 0 76543210 -
W 0201 1 0 0000dead E
W 0202 2 0 ffffffff E
W 0203 1 0 0000beef E
W 0201 2 0 12341234 E
R 0200 2 0 0 76543210
R 0201 1 0 0 E
R 0203 1 1 0 E
R 0202 2 0 0 E
R 0203 2 0 0 E
R 0200 2 0 0 76543210
W 0202 1 0 00009abc -
R 0200 2 0 0 9abc3210
# Back to back traffic
W 0300 2 0 01020304 -
R+ 0300 2 0 0 01020304
W+ 0304 2 0 05060708 -
R+ 0304 2 0 0 05060708
R+ 0300 0 0 0 00000004
R+ 0304 2 0 0 05060708
R+ 0008 2 0 0 99aabbcc
R+ 000c 0 1 0 00000000
R+ 000d 0 0 0 ffffffff
R+ 000e 1 0 0 ffffddee
W+ 0300 0 0 00000080 -
R+ 0300 2 0 0 01020380
R+ 0300 0 0 0 ffffff80
R+ 0201 1 0 0 E
R+ 0200 2 0 0 9abc3210
W+ 0200 1 0 00005555 -
R+ 0200 2 0 0 9abc5555
R+ 0202 1 1 0 00009abc
R+ 0000 2 0 0 11223344
R+ 0010 2 0 0 a5a5a5a5

// File: test/tb_banked_mem.sv
// ####################
// Banked memory testbench
// Replays the case file, checks load data and error pulses
// ####################

`include "mem_settings.svh"

module tb_banked_mem
    import mem_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int kind_none = 0;   // Store, no response
    localparam int kind_data = 1;
    localparam int kind_err  = 2;

    logic               clk;
    logic               arst_n_i;
    logic               req_i;
    logic               we_i;
    logic [`MEM_AW-1:0] addr_i;
    access_size_e       size_i;
    logic               unsigned_i;
    mem_word_u          wdata_i;
    logic               rvalid_o;
    logic               err_o;
    mem_word_u          rdata_o;

    // Cases as read from the file
    logic               case_we [$];
    logic [`MEM_AW-1:0] case_addr [$];
    access_size_e       case_size [$];
    logic               case_uns [$];
    mem_word_u          case_wdata [$];
    int                 case_kind [$];
    mem_word_u          case_exp [$];
    int                 case_line [$];
    logic               case_b2b [$];

    // Responses still owed by the DUT
    int                 exp_kind_q [$];
    mem_word_u          exp_data_q [$];
    int                 exp_idx_q [$];

    logic               pend;
    int                 mon_kind;
    mem_word_u          mon_data;
    int                 mon_idx;
    int                 cycle_count;
    int                 cycle_limit;

    banked_mem dut0 (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .req_i      (req_i),
        .we_i       (we_i),
        .addr_i     (addr_i),
        .size_i     (size_i),
        .unsigned_i (unsigned_i),
        .wdata_i    (wdata_i),
        .rvalid_o   (rvalid_o),
        .err_o      (err_o),
        .rdata_o    (rdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ####################
    // Helpers
    // ####################

    task automatic stop_on_failure();
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped at first failure");
    endtask

    // Hex digits of a token, anything else skipped
    function automatic mem_word_u word_from_hex(input logic [8*12-1:0] s);
        logic [31:0] v;
        logic [7:0]  c;
        v = '0;
        for (int i = 11; i >= 0; i--) begin
            c = s[i*8 +: 8];
            if (c >= "0" && c <= "9") begin
                v = {v[27:0], 4'(c - "0")};
            end else if (c >= "a" && c <= "f") begin
                v = {v[27:0], 4'(c - "a" + 10)};
            end else if (c >= "A" && c <= "F") begin
                v = {v[27:0], 4'(c - "A" + 10)};
            end
        end
        return mem_word_u'(v);
    endfunction

    task automatic check_err(input logic exp_err, input logic exp_valid, input int idx);
        if (err_o !== exp_err || rvalid_o !== exp_valid) begin
            $display("Mismatch at %0t: case %0d (line %0d) err_o=%b rvalid_o=%b, expected %b %b",
                     $time, idx, case_line[idx], err_o, rvalid_o, exp_err, exp_valid);
            stop_on_failure();
        end
    endtask

    task automatic check_data(input mem_word_u exp, input int idx);
        if (rvalid_o === 1'b1 && rdata_o !== exp) begin
            $display("Mismatch at %0t: case %0d (line %0d) rdata_o=%h, expected %h",
                     $time, idx, case_line[idx], rdata_o, exp);
            stop_on_failure();
        end
    endtask

    // ####################
    // Response monitor
    // ####################

    // Outputs settle after the edge, so look at the falling edge
    initial pend = 1'b0;

    always @(negedge clk) begin
        if (arst_n_i) begin
            if (pend) begin
                if (exp_kind_q.size() == 0) begin
                    $display("Request was seen but no expected response was queued");
                    stop_on_failure();
                end
                mon_kind = exp_kind_q.pop_front();
                mon_data = exp_data_q.pop_front();
                mon_idx  = exp_idx_q.pop_front();
                check_err(mon_kind == kind_err, mon_kind == kind_data, mon_idx);
                if (mon_kind == kind_data) begin
                    check_data(mon_data, mon_idx);
                end
            end else if (rvalid_o === 1'b1 || err_o === 1'b1) begin
                $display("Response strobe at %0t with no request pending", $time);
                stop_on_failure();
            end
            pend = req_i;
        end
    end

    // ####################
    // Timeout
    // ####################

    initial begin
        cycle_count = 0;
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
                $display("Timeout: run did not finish within %0d cycles", cycle_limit);
                stop_on_failure();
            end
        end
    end

    // ####################
    // Case file and stimulus
    // ####################

    initial begin : main_seq
        int                 fd;
        int                 n;
        int                 line_no;
        int                 idle;
        int                 size_v;
        int                 uns_v;
        logic [8*128-1:0]   line_buf;
        logic [15:0]        op_s;
        logic [31:0]        addr_v;
        logic [31:0]        wdata_v;
        logic [8*12-1:0]    exp_s;

        cycle_limit = 0;
        arst_n_i    = 1'b0;
        req_i       = 1'b0;
        we_i        = 1'b0;
        addr_i      = '0;
        size_i      = size_word;
        unsigned_i  = 1'b0;
        wdata_i     = '0;
        void'($urandom(32'hc855_79ce));

        fd = $fopen("test/mem_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file test/mem_cases.txt");
            stop_on_failure();
        end
        line_no = 0;
        while (!$feof(fd)) begin
            line_buf = '0;
            op_s     = '0;
            exp_s    = '0;
            if ($fgets(line_buf, fd) != 0) begin
                line_no++;
                n = $sscanf(line_buf, "%s %h %d %d %h %s",
                            op_s, addr_v, size_v, uns_v, wdata_v, exp_s);
                if (n > 0 && op_s != "#") begin
                    if (n != 6 || !(op_s inside {"W", "R", "W+", "R+"})) begin
                        $display("Malformed line %0d in the case file", line_no);
                        stop_on_failure();
                    end
                    case_we.push_back(op_s[15:8] == "W" || op_s[7:0] == "W");
                    case_b2b.push_back(op_s[7:0] == "+");
                    case_addr.push_back(addr_v[`MEM_AW-1:0]);
                    case_size.push_back(access_size_e'(size_v[1:0]));
                    case_uns.push_back(uns_v[0]);
                    case_wdata.push_back(mem_word_u'(wdata_v));
                    case_line.push_back(line_no);
                    if (exp_s == "E") begin
                        case_kind.push_back(kind_err);
                    end else if (exp_s == "-") begin
                        case_kind.push_back(kind_none);
                    end else begin
                        case_kind.push_back(kind_data);
                    end
                    case_exp.push_back(word_from_hex(exp_s));
                end
            end
        end
        $fclose(fd);
        cycle_limit = case_we.size() * 4 + 20;

        repeat (8) @(posedge clk);
        arst_n_i <= 1'b1;

        for (int k = 0; k < case_we.size(); k++) begin
            idle = case_b2b[k] ? 0 : ($urandom % 3);
            repeat (idle) begin
                @(posedge clk);
                req_i <= 1'b0;
            end
            @(posedge clk);
            req_i      <= 1'b1;
            we_i       <= case_we[k];
            addr_i     <= case_addr[k];
            size_i     <= case_size[k];
            unsigned_i <= case_uns[k];
            wdata_i    <= case_wdata[k];
            exp_kind_q.push_back(case_kind[k]);
            exp_data_q.push_back(case_exp[k]);
            exp_idx_q.push_back(k);
        end
        @(posedge clk);
        req_i <= 1'b0;

        // Drain the last responses
        while (exp_kind_q.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: verilog/bank_sel.sv
// ####################
// Bank request decode
// Splits the byte address, checks alignment, places store lanes
// ####################

`include "mem_settings.svh"

module bank_sel
    import mem_pkg::*;
(
    input  logic                       req_i,
    input  logic                       we_i,
    input  logic [`MEM_AW-1:0]         addr_i,
    input  access_size_e               size_i,
    input  mem_word_u                  wdata_i,
    output logic [`MEM_BANKS-1:0]      bank_sel_o,
    output logic [`MEM_BANK_AW-1:0]    bank_addr_o,
    output logic                       bank_we_o,
    output logic [3:0]                 bank_mask_o,
    output mem_word_u                  bank_wdata_o,
    output logic                       load_o,
    output logic                       misaligned_o,
    output logic [`MEM_BANK_SEL_W-1:0] bank_idx_o
);

    logic [1:0] lane;
    logic       misaligned;
    logic       accept;

    // ####################
    // Address split
    // ####################

    assign lane        = addr_i[1:0];
    assign bank_idx_o  = addr_i[2 +: `MEM_BANK_SEL_W];
    assign bank_addr_o = addr_i[`MEM_AW-1 -: `MEM_BANK_AW];

    always_comb begin
        case (size_i)
            size_byte: misaligned = 1'b0;
            size_half: misaligned = lane[0];
            size_word: misaligned = |lane;
            default:   misaligned = 1'b1;   // Undefined size code
        endcase
    end

    assign accept       = req_i & ~misaligned;
    assign misaligned_o = req_i & misaligned;
    assign load_o       = accept & ~we_i;
    assign bank_we_o    = accept & we_i;
    assign bank_sel_o   = accept ? (`MEM_BANKS'(1) << bank_idx_o) : '0;

    // ####################
    // Store lane placement
    // ####################

    always_comb begin
        bank_wdata_o = wdata_i;             // Word uses all lanes
        bank_mask_o  = 4'b1111;
        case (size_i)
            size_byte: begin
                for (int i = 0; i < 4; i++) begin
                    bank_wdata_o.bytes[i] = wdata_i.bytes[0];
                end
                bank_mask_o = 4'b0001 << lane;
            end
            size_half: begin
                bank_wdata_o.halves[0] = wdata_i.halves[0];
                bank_wdata_o.halves[1] = wdata_i.halves[0];
                bank_mask_o = lane[1] ? 4'b1100 : 4'b0011;
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/banked_mem.sv
// ####################
// Banked data memory
// Four word-interleaved banks behind one request port
// ####################

`include "mem_settings.svh"

module banked_mem
    import mem_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               req_i,
    input  logic               we_i,
    input  logic [`MEM_AW-1:0] addr_i,
    input  access_size_e       size_i,
    input  logic               unsigned_i,
    input  mem_word_u          wdata_i,
    output logic               rvalid_o,
    output logic               err_o,
    output mem_word_u          rdata_o
);

    logic [`MEM_BANKS-1:0]      bank_sel;
    logic [`MEM_BANK_AW-1:0]    bank_addr;
    logic                       bank_we;
    logic [3:0]                 bank_mask;
    mem_word_u                  bank_wdata;
    logic                       load;
    logic                       misaligned;
    logic [`MEM_BANK_SEL_W-1:0] bank_idx;
    logic [31:0]                bank_rdata [`MEM_BANKS];

    bank_sel u_bank_sel (
        .req_i        (req_i),
        .we_i         (we_i),
        .addr_i       (addr_i),
        .size_i       (size_i),
        .wdata_i      (wdata_i),
        .bank_sel_o   (bank_sel),
        .bank_addr_o  (bank_addr),
        .bank_we_o    (bank_we),
        .bank_mask_o  (bank_mask),
        .bank_wdata_o (bank_wdata),
        .load_o       (load),
        .misaligned_o (misaligned),
        .bank_idx_o   (bank_idx)
    );

    for (genvar i = 0; i < `MEM_BANKS; i++) begin : g_bank
        spram u_spram (
            .clk          (clk),
            .sel_i        (bank_sel[i]),
            .wr_en_i      (bank_we),
            .wr_mask_i    (bank_mask),
            .address_in_i (bank_addr),
            .data_in_i    (bank_wdata),
            .data_out_o   (bank_rdata[i])
        );
    end

    load_align u_load_align (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .load_i       (load),
        .misaligned_i (misaligned),
        .bank_idx_i   (bank_idx),
        .lane_i       (addr_i[1:0]),
        .size_i       (size_i),
        .unsigned_i   (unsigned_i),
        .bank_rdata_i (bank_rdata),
        .rvalid_o     (rvalid_o),
        .err_o        (err_o),
        .rdata_o      (rdata_o)
    );

endmodule

// File: verilog/load_align.sv
// ####################
// Load return path
// Picks the answering bank, extracts and extends the load value
// ####################

`include "mem_settings.svh"

module load_align
    import mem_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n_i,
    input  logic                       load_i,
    input  logic                       misaligned_i,
    input  logic [`MEM_BANK_SEL_W-1:0] bank_idx_i,
    input  logic [1:0]                 lane_i,
    input  access_size_e               size_i,
    input  logic                       unsigned_i,
    input  logic [31:0]                bank_rdata_i [`MEM_BANKS],
    output logic                       rvalid_o,
    output logic                       err_o,
    output mem_word_u                  rdata_o
);

    logic [`MEM_BANK_SEL_W-1:0] bank_idx_q;
    logic [1:0]                 lane_q;
    access_size_e               size_q;
    logic                       unsigned_q;
    mem_word_u                  rd_word;
    logic [7:0]                 rd_byte;
    logic [15:0]                rd_half;

    // ####################
    // Request stage
    // ####################

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rvalid_o <= 1'b0;
            err_o    <= 1'b0;
        end else begin
            rvalid_o <= load_i;
            err_o    <= misaligned_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin                   // Fields of the pending load
            bank_idx_q <= bank_idx_i;
            lane_q     <= lane_i;
            size_q     <= size_i;
            unsigned_q <= unsigned_i;
        end
    end

    // ####################
    // Extract and extend
    // ####################

    assign rd_word = bank_rdata_i[bank_idx_q];
    assign rd_byte = rd_word.bytes[lane_q];
    assign rd_half = rd_word.halves[lane_q[1]];

    always_comb begin
        case (size_q)
            size_byte: rdata_o = {{24{rd_byte[7] & ~unsigned_q}}, rd_byte};
            size_half: rdata_o = {{16{rd_half[15] & ~unsigned_q}}, rd_half};
            default:   rdata_o = rd_word;
        endcase
    end

endmodule

// File: verilog/mem_pkg.sv
// ####################
// Banked memory types
// Access size and byte/halfword word views
// ####################

package mem_pkg;

    // ####################
    // Access size
    // ####################

    typedef enum logic [1:0] {
        size_byte = 2'd0,   // 8 bit
        size_half = 2'd1,   // 16 bit, lane bit 0 clear
        size_word = 2'd2    // 32 bit, both lane bits clear
    } access_size_e;

    // ####################
    // Data word
    // ####################

    // Same 32 bits seen as lanes or as halves
    typedef union packed {
        logic [3:0][7:0]  bytes;    // Lane 0 is bits 7:0
        logic [1:0][15:0] halves;   // Half 0 is bits 15:0
    } mem_word_u;

endpackage

// File: verilog/mem_settings.svh
// ####################
// Banked memory sizing
// Bank count, bank depth and address widths
// ####################

`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Interleaved banks, power of two
`define MEM_BANKS 4

// Bank index width, log2 of MEM_BANKS
`define MEM_BANK_SEL_W 2

// Word address inside one bank
`define MEM_BANK_AW 10

// Byte address: lane bits, bank index, bank word
`define MEM_AW (2 + `MEM_BANK_SEL_W + `MEM_BANK_AW)

`endif

// File: verilog/spram.sv
// ####################
// Single-port RAM bank
// 32-bit words, per-byte write mask, registered read
// ####################

`include "mem_settings.svh"

module spram (
    input  logic                    clk,
    input  logic                    sel_i,
    input  logic                    wr_en_i,
    input  logic [3:0]              wr_mask_i,
    input  logic [`MEM_BANK_AW-1:0] address_in_i,
    input  logic [31:0]             data_in_i,
    output logic [31:0]             data_out_o
);

    localparam int DEPTH = 2 ** `MEM_BANK_AW;

    logic [31:0] memory [DEPTH];

    // ####################
    // Masked write
    // ####################

    always_ff @(posedge clk) begin
        if (sel_i && wr_en_i) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_mask_i[i]) begin
                    memory[address_in_i][i*8 +: 8] <= data_in_i[i*8 +: 8];
                end
            end
        end
    end

    // ####################
    // Registered read
    // ####################

    // Old word on a write cycle, output holds while idle
    always_ff @(posedge clk) begin
        if (sel_i) begin
            data_out_o <= memory[address_in_i];
        end
    end

endmodule
